//--- tests/sprint_patterns.txt
# S start | L type r0 c0 r1 c1 r2 c2 r3 c3 (decimal) | W cycles
# R row then tiles of col 0..9 (hex) | C expected lines count
R 0 0 0 0 0 0 0 0 0 0 0
R 19 0 0 0 0 0 0 0 0 0 0
L 1 16 0 17 0 18 0 19 0
R 19 0 0 0 0 0 0 0 0 0 0
C 0
S
L 1 16 0 17 0 18 0 19 0
L 2 18 1 18 2 19 1 19 2
R 19 1 2 2 0 0 0 0 0 0 0
R 17 1 0 0 0 0 0 0 0 0 0
L 3 16 3 17 3 18 3 19 3
L 4 16 4 17 4 18 4 19 4
L 5 16 5 17 5 18 5 19 5
L 6 16 6 17 6 18 6 19 6
L 7 16 7 17 7 18 7 19 7
L 1 16 8 17 8 18 8 19 8
L 1 16 9 17 9 18 9 19 9
R 19 1 0 0 3 4 5 6 7 1 1
R 18 1 0 0 3 4 5 6 7 1 1
R 17 0 0 0 0 0 0 0 0 0 0
C 2
L 2 18 1 18 2 19 1 19 2
R 19 0 0 0 0 0 0 0 0 0 0
C 4
W 120000
L 1 16 0 17 0 18 0 19 0
L 2 16 1 17 1 18 1 19 1
L 3 16 2 17 2 18 2 19 2
L 4 16 3 17 3 18 3 19 3
L 5 16 4 17 4 18 4 19 4
L 6 16 5 17 5 18 5 19 5
L 7 16 6 17 6 18 6 19 6
L 1 16 7 17 7 18 7 19 7
L 2 16 8 17 8 18 8 19 8
L 6 17 9 19 9 31 15 20 9
R 19 1 2 3 4 5 6 7 1 2 0
R 18 1 2 3 4 5 6 7 1 2 0
R 17 0 0 0 0 0 0 0 0 0 0
C 6
L 7 16 9 17 9 18 9 19 9
C 8
R 19 0 0 0 0 0 0 0 0 0 7
R 18 0 0 0 0 0 0 0 0 0 7
R 17 0 0 0 0 0 0 0 0 0 0
W 200
L 1 16 0 17 0 18 0 19 0
R 17 0 0 0 0 0 0 0 0 0 0
R 19 0 0 0 0 0 0 0 0 0 7
C 8
S
R 19 0 0 0 0 0 0 0 0 0 0
R 18 0 0 0 0 0 0 0 0 0 0
C 0

//--- sim.f
src/tetris_pkg.sv
src/sprint_fsm.sv
src/sprint_timer.sv
src/playfield.sv
src/sprint_top.sv
tests/tb_sprint.sv

//--- Makefile
# Verilator build and run for the sprint core testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module tb_sprint -f sim.f

run: build
	./obj_dir/Vtb_sprint | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --top-module sprint_top \
		src/tetris_pkg.sv src/sprint_fsm.sv src/sprint_timer.sv \
		src/playfield.sv src/sprint_top.sv

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_sprint.sv
// ====================
// runs the records in tests/sprint_patterns.txt from the project root
// stops at the first mismatch, time is only checked once the sprint is over
// ====================
`timescale 1ns/100ps

module tb_sprint;

    logic                     clk;
    logic                     arst_n;
    logic                     start;
    logic                     lock;
    tetris_pkg::piece_lock_t  piece;
    tetris_pkg::row_idx_t     row_sel;
    tetris_pkg::game_state_t  state;
    tetris_pkg::lines_t       lines_cleared;
    tetris_pkg::sprint_time_t sprint_time;
    logic                     settled;
    tetris_pkg::field_row_t   row_cells;

    string                   records[$];
    tetris_pkg::game_state_t model_state;
    int                      sprint_cycles;
    int                      cycle_count;
    int                      cycle_limit;

    sprint_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .lock          (lock),
        .piece         (piece),
        .row_sel       (row_sel),
        .state         (state),
        .lines_cleared (lines_cleared),
        .sprint_time   (sprint_time),
        .settled       (settled),
        .row_cells     (row_cells)
    );

    always #50 clk = ~clk;

    // cycles that end in SPRINT, restarted by an accepted start
    always @(posedge clk) begin
        if (start && state != tetris_pkg::SPRINT) begin
            sprint_cycles = 0;
        end else if (state == tetris_pkg::SPRINT) begin
            sprint_cycles = sprint_cycles + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    // first cycle only clears the prescaler, each later one advances it
    function automatic tetris_pkg::sprint_time_t expected_time(input int cycles);
        tetris_pkg::sprint_time_t t;
        int                       ms;
        ms             = (cycles > 0) ? (cycles - 1) / tetris_pkg::CYCLES_PER_MS : 0;
        t.minutes      = 6'((ms / 60000) % 60);
        t.seconds      = 6'((ms / 1000) % 60);
        t.deciseconds  = 4'((ms / 100) % 10);
        t.centiseconds = 4'((ms / 10) % 10);
        t.milliseconds = 4'(ms % 10);
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic wait_settled();
        while (!settled) begin
            next_cycle();
        end
    endtask

    task automatic load_records();
        int    fd;
        int    n;
        string line;
        string cmd;
        fd = $fopen("tests/sprint_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/sprint_patterns.txt");
            $display("Checks failed");
            $fatal(1);
        end
        cycle_limit = 5;
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%s", cmd) == 1 && cmd.getc(0) != "#") begin
                records.push_back(line);
                if (cmd == "W" && $sscanf(line, "%s %d", cmd, n) == 2) begin
                    cycle_limit += n;
                end else begin
                    cycle_limit += 64;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_record(input string line);
        string                    cmd;
        int                       a[11];
        tetris_pkg::field_row_t   exp_row;
        tetris_pkg::sprint_time_t held;
        void'($sscanf(line, "%s", cmd));
        if (cmd == "S") begin
            start = 1'b1;
            next_cycle();
            start       = 1'b0;
            model_state = tetris_pkg::SPRINT;
            check_value("state", 32'(state), 32'(model_state));
            next_cycle();
            check_value("lines_cleared", 32'(lines_cleared), 0);
            check_value("sprint_time", 32'(sprint_time), 0);
        end else if (cmd == "L") begin
            void'($sscanf(line, "%s %d %d %d %d %d %d %d %d %d", cmd, a[0],
                          a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8]));
            wait_settled();
            piece.tile = tetris_pkg::tile_type_t'(a[0]);
            for (int i = 0; i < tetris_pkg::PIECE_CELLS; i++) begin
                piece.cells[i].row = tetris_pkg::row_idx_t'(a[2*i+1]);
                piece.cells[i].col = tetris_pkg::col_idx_t'(a[2*i+2]);
            end
            lock = 1'b1;
            next_cycle();
            lock = 1'b0;
        end else if (cmd == "W") begin
            void'($sscanf(line, "%s %d", cmd, a[0]));
            held = sprint_time;
            repeat (a[0]) next_cycle();
            if (model_state == tetris_pkg::DONE) begin
                check_value("sprint_time", 32'(sprint_time), 32'(held));
                check_value("sprint_time", 32'(sprint_time), 32'(expected_time(sprint_cycles)));
            end
        end else if (cmd == "R") begin
            void'($sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h", cmd, a[0],
                          a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8], a[9], a[10]));
            for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                exp_row[c] = tetris_pkg::tile_type_t'(a[c+1]);
            end
            wait_settled();
            row_sel = tetris_pkg::row_idx_t'(a[0]);
            next_cycle();
            check_value($sformatf("row_cells[%0d]", a[0]), 32'(row_cells), 32'(exp_row));
        end else if (cmd == "C") begin
            void'($sscanf(line, "%s %d", cmd, a[0]));
            wait_settled();
            check_value("lines_cleared", 32'(lines_cleared), a[0]);
            // the state register follows the count one edge later
            if (model_state != tetris_pkg::IDLE && a[0] >= tetris_pkg::SPRINT_LINES) begin
                next_cycle();
                model_state = tetris_pkg::DONE;
                check_value("sprint_time", 32'(sprint_time), 32'(expected_time(sprint_cycles)));
            end
            check_value("state", 32'(state), 32'(model_state));
        end else begin
            $display("unknown record in the pattern file: %s", line);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    initial begin
        clk           = 1'b0;
        arst_n        = 1'b0;
        start         = 1'b0;
        lock          = 1'b0;
        piece         = '0;
        row_sel       = '0;
        model_state   = tetris_pkg::IDLE;
        sprint_cycles = 0;
        cycle_count   = 0;
        load_records();
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;
        check_value("state", 32'(state), 32'(tetris_pkg::IDLE));
        check_value("lines_cleared", 32'(lines_cleared), 0);
        check_value("sprint_time", 32'(sprint_time), 0);
        check_value("settled", 32'(settled), 1);
        foreach (records[k]) begin
            run_record(records[k]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- src/sprint_top.sv
// ====================
// sprint core top level, pieces arrive already placed via lock
// a lock is dropped unless settled is high during a sprint
// ====================
`timescale 1ns/100ps

module sprint_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     lock,
    input  tetris_pkg::piece_lock_t  piece,
    input  tetris_pkg::row_idx_t     row_sel,
    output tetris_pkg::game_state_t  state,
    output tetris_pkg::lines_t       lines_cleared,
    output tetris_pkg::sprint_time_t sprint_time,
    output logic                     settled,
    output tetris_pkg::field_row_t   row_cells
);

    logic                  game_start;
    tetris_pkg::row_mask_t full_rows;

    sprint_fsm fsm_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .start         (start),
        .full_rows     (full_rows),
        .state         (state),
        .game_start    (game_start),
        .lines_cleared (lines_cleared)
    );

    sprint_timer timer_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .state       (state),
        .game_start  (game_start),
        .sprint_time (sprint_time)
    );

    // locked cells, line clear and collapse
    playfield pf_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .state      (state),
        .game_start (game_start),
        .lock       (lock),
        .piece      (piece),
        .row_sel    (row_sel),
        .row_cells  (row_cells),
        .full_rows  (full_rows),
        .settled    (settled)
    );

endmodule

//--- src/playfield.sv
// ====================
// locked cells with line clear and one-row-per-cycle collapse
// locks are taken only while settled, overlapping cells are not checked
// ====================
`timescale 1ns/100ps

module playfield (
    input  logic                    clk,
    input  logic                    arst_n,
    input  tetris_pkg::game_state_t state,
    input  logic                    game_start,
    input  logic                    lock,
    input  tetris_pkg::piece_lock_t piece,
    input  tetris_pkg::row_idx_t    row_sel,
    output tetris_pkg::field_row_t  row_cells,
    output tetris_pkg::row_mask_t   full_rows,
    output logic                    settled
);

    tetris_pkg::field_row_t cells [tetris_pkg::PLAYFIELD_ROWS];
    tetris_pkg::row_mask_t  empty_rows;
    tetris_pkg::row_mask_t  fall_rows;
    logic                   lock_ok;

    // classify each row
    always_comb begin
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            full_rows[r]  = 1'b1;
            empty_rows[r] = 1'b1;
            for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                if (cells[r][c] == tetris_pkg::BLANK) begin
                    full_rows[r] = 1'b0;
                end else begin
                    empty_rows[r] = 1'b0;
                end
            end
        end
    end

    // an empty row with something above it pulls down the row on top,
    // held off while a full row is still waiting to clear
    always_comb begin
        logic seen;
        seen      = 1'b0;
        fall_rows = '0;
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            fall_rows[r] = empty_rows[r] && seen && !(|full_rows);
            seen         = seen || !empty_rows[r];
        end
    end

    assign settled = !(|full_rows) && !(|fall_rows);
    assign lock_ok = lock && settled && !game_start && (state == tetris_pkg::SPRINT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                cells[r] <= tetris_pkg::EMPTY_ROW;
            end
        end else if (game_start) begin
            for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                cells[r] <= tetris_pkg::EMPTY_ROW;
            end
        end else begin
            for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                if (full_rows[r]) begin
                    cells[r] <= tetris_pkg::EMPTY_ROW;
                end
            end
            // blank first so a falling row above can overwrite it
            for (int r = 1; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                if (fall_rows[r]) begin
                    cells[r-1] <= tetris_pkg::EMPTY_ROW;
                end
            end
            for (int r = 1; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                if (fall_rows[r]) begin
                    cells[r] <= cells[r-1];
                end
            end
            if (lock_ok) begin
                for (int i = 0; i < tetris_pkg::PIECE_CELLS; i++) begin
                    if (piece.cells[i].row < tetris_pkg::row_idx_t'(tetris_pkg::PLAYFIELD_ROWS) &&
                        piece.cells[i].col < tetris_pkg::col_idx_t'(tetris_pkg::PLAYFIELD_COLS)) begin
                        cells[piece.cells[i].row][piece.cells[i].col] <= piece.tile;
                    end
                end
            end
        end
    end

    // rows past the bottom read as blank
    always_comb begin
        if (row_sel < tetris_pkg::row_idx_t'(tetris_pkg::PLAYFIELD_ROWS)) begin
            row_cells = cells[row_sel];
        end else begin
            row_cells = tetris_pkg::EMPTY_ROW;
        end
    end

endmodule

//--- src/sprint_timer.sv
// ====================
// sprint clock in decimal digits
// one millisecond per CYCLES_PER_MS clock cycles
// minutes wrap after 59 and the value holds outside a sprint
// ====================
`timescale 1ns/100ps

module sprint_timer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  tetris_pkg::game_state_t  state,
    input  logic                     game_start,
    output tetris_pkg::sprint_time_t sprint_time
);

    logic [tetris_pkg::MS_PRESCALE_W-1:0] prescale;
    logic                                 tick_ms;
    logic                                 wrap_ms;
    logic                                 wrap_cs;
    logic                                 wrap_ds;
    logic                                 wrap_s;

    // each wrap feeds the next digit in the same edge
    always_comb begin
        tick_ms = prescale ==
                  tetris_pkg::MS_PRESCALE_W'(tetris_pkg::CYCLES_PER_MS - 1);
        wrap_ms = tick_ms && (sprint_time.milliseconds == 4'd9);
        wrap_cs = wrap_ms && (sprint_time.centiseconds == 4'd9);
        wrap_ds = wrap_cs && (sprint_time.deciseconds == 4'd9);
        wrap_s  = wrap_ds && (sprint_time.seconds == 6'd59);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prescale    <= '0;
            sprint_time <= '0;
        end else if (game_start) begin
            prescale    <= '0;
            sprint_time <= '0;
        end else if (state == tetris_pkg::SPRINT) begin
            prescale <= tick_ms ? '0 : prescale + tetris_pkg::MS_PRESCALE_W'(1);
            if (tick_ms) begin
                sprint_time.milliseconds <= wrap_ms ? 4'd0 : sprint_time.milliseconds + 4'd1;
            end
            if (wrap_ms) begin
                sprint_time.centiseconds <= wrap_cs ? 4'd0 : sprint_time.centiseconds + 4'd1;
            end
            if (wrap_cs) begin
                sprint_time.deciseconds <= wrap_ds ? 4'd0 : sprint_time.deciseconds + 4'd1;
            end
            if (wrap_ds) begin
                sprint_time.seconds <= wrap_s ? 6'd0 : sprint_time.seconds + 6'd1;
            end
            if (wrap_s) begin
                if (sprint_time.minutes == 6'd59) begin
                    sprint_time.minutes <= 6'd0;
                end else begin
                    sprint_time.minutes <= sprint_time.minutes + 6'd1;
                end
            end
        end
    end

endmodule

//--- src/sprint_fsm.sv
// ====================
// game state and lines count, start is ignored during a sprint
// ====================
`timescale 1ns/100ps

module sprint_fsm (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  tetris_pkg::row_mask_t   full_rows,
    output tetris_pkg::game_state_t state,
    output logic                    game_start,
    output tetris_pkg::lines_t      lines_cleared
);

    tetris_pkg::game_state_t state_next;
    tetris_pkg::lines_t      rows_now;
    logic                    start_go;

    assign start_go = start && (state != tetris_pkg::SPRINT);

    // number of rows clearing this cycle
    always_comb begin
        rows_now = '0;
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            rows_now = rows_now + tetris_pkg::lines_t'(full_rows[r]);
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            tetris_pkg::IDLE,
            tetris_pkg::DONE: begin
                if (start) begin
                    state_next = tetris_pkg::SPRINT;
                end
            end
            tetris_pkg::SPRINT: begin
                if (lines_cleared >= tetris_pkg::lines_t'(tetris_pkg::SPRINT_LINES)) begin
                    state_next = tetris_pkg::DONE;
                end
            end
            default: state_next = tetris_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= tetris_pkg::IDLE;
            game_start    <= 1'b0;
            lines_cleared <= '0;
        end else begin
            state      <= state_next;
            // high only in the first sprint cycle
            game_start <= start_go;
            if (start_go) begin
                lines_cleared <= '0;
            end else begin
                lines_cleared <= lines_cleared + rows_now;
            end
        end
    end

endmodule

//--- src/tetris_pkg.sv
// ====================
// shared types and sizes for the sprint core
// row 0 is the top of the field, column 0 sits in the low bits of a row
// ====================

package tetris_pkg;

    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;
    localparam int PIECE_CELLS    = 4;

    // short sprint target
    localparam int SPRINT_LINES   = 8;

    // 50 MHz clock
    localparam int CYCLES_PER_MS  = 50_000;
    localparam int MS_PRESCALE_W  = $clog2(CYCLES_PER_MS);

    typedef enum logic [2:0] {
        BLANK,
        I,
        O,
        T,
        S,
        Z,
        J,
        L
    } tile_type_t;

    typedef enum logic [1:0] {
        IDLE,
        SPRINT,
        DONE
    } game_state_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } cell_t;

    typedef struct packed {
        tile_type_t                   tile;
        cell_t [PIECE_CELLS-1:0]      cells;
    } piece_lock_t;

    typedef tile_type_t [PLAYFIELD_COLS-1:0] field_row_t;
    typedef logic [PLAYFIELD_ROWS-1:0]       row_mask_t;
    typedef logic [7:0]                      lines_t;

    localparam field_row_t EMPTY_ROW = '{default: BLANK};

    typedef struct packed {
        logic [5:0] minutes;
        logic [5:0] seconds;
        logic [3:0] deciseconds;
        logic [3:0] centiseconds;
        logic [3:0] milliseconds;
    } sprint_time_t;

endpackage
